// File: Makefile
# Verilator build and run for the min-cost arbiter

TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= arb_tb
FLIST      ?= flist.f
BUILD      ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

# pass is decided by the log, not by the exit status of the binary
run: build
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: flist.f
src/arb_pkg.sv
src/ones_counter.sv
src/min_finder.sv
src/req_analyzer.sv
src/result_fifo.sv
src/grant_encoder.sv
src/min_cost_arbiter.sv
verif/arb_tb.sv

// File: src/arb_pkg.sv
package arb_pkg;

    // lane geometry
    localparam int NUM_LANES  = 8;
    localparam int LANE_W     = 3;

    // raw lane cost
    localparam int COST_W     = 5;
    // top bit set when the lane is not requesting, so it loses to any requester
    localparam int EXT_COST_W = COST_W + 1;

    // request count covers 0 to NUM_LANES
    localparam int COUNT_W    = 4;

    // carry-sum counter layout
    // two 7-bit groups plus one leftover bit give a 15-bit counter input
    localparam int CS_GROUP_W = 7;
    localparam int PC_IN_W    = 2 * CS_GROUP_W + 1;

    // result buffer between producer and consumer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

    // one incoming transaction
    typedef struct packed {
        // one request bit per lane
        logic [NUM_LANES-1:0]             mask;
        // lane i cost sits in costs[i]
        logic [NUM_LANES-1:0][COST_W-1:0] costs;
    } req_t;

    // producer result, still one-hot
    typedef struct packed {
        logic [COUNT_W-1:0]               count;
        // one-hot, lowest cost and lowest index on ties
        logic [NUM_LANES-1:0]             winner;
        // raw costs, consumer picks the winner's cost out of these
        logic [NUM_LANES-1:0][COST_W-1:0] costs;
    } analysis_t;

    // final answer presented at the top level
    typedef struct packed {
        logic [COUNT_W-1:0] count;
        // zero when nobody requests
        logic [LANE_W-1:0]  index;
        // zero when nobody requests
        logic [COST_W-1:0]  cost;
    } grant_t;

endpackage

// File: src/grant_encoder.sv
`timescale 1ns/1ps

module grant_encoder import arb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      buf_valid,
    output logic      buf_ready,
    input  analysis_t buf_data,
    output logic      out_valid,
    input  logic      out_ready,
    output grant_t    out_grant
);

    // lane numbers gated by their one-hot bit
    logic [NUM_LANES-1:0][LANE_W-1:0] lane_gated;
    logic [LANE_W-1:0]                win_index;
    logic [COST_W-1:0]                win_cost;
    grant_t                           next_grant;
    logic                             take;

    // and stage of the one-hot to binary mux
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_gate
        assign lane_gated[i] = {LANE_W{buf_data.winner[i]}} & LANE_W'(i);
    end

    // or stage, only one lane survives the gating
    always_comb begin
        win_index = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            win_index = win_index | lane_gated[i];
        end
    end

    // binary-select mux for the winner's cost
    assign win_cost = buf_data.costs[win_index];

    // empty request reports lane zero at cost zero
    always_comb begin
        next_grant.count = buf_data.count;
        if (buf_data.count == '0) begin
            next_grant.index = '0;
            next_grant.cost  = '0;
        end else begin
            next_grant.index = win_index;
            next_grant.cost  = win_cost;
        end
    end

    // single output register, free when empty or draining
    assign buf_ready = !out_valid || out_ready;
    assign take      = buf_valid && buf_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (buf_ready) begin
            out_valid <= buf_valid;
        end
    end

    // grant payload held while the receiver stalls
    always_ff @(posedge clk) begin
        if (take) begin
            out_grant <= next_grant;
        end
    end

endmodule

// File: src/min_cost_arbiter.sv
`timescale 1ns/1ps

module min_cost_arbiter import arb_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    output logic   in_ready,
    input  req_t   in_req,
    output logic   out_valid,
    input  logic   out_ready,
    output grant_t out_grant
);

    // producer to buffer
    logic      ana_valid;
    logic      ana_ready;
    analysis_t ana_data;

    // buffer to consumer
    logic      buf_valid;
    logic      buf_ready;
    analysis_t buf_data;

    // count and one-hot winner, registered
    req_analyzer req_analyzer_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .ana_valid (ana_valid),
        .ana_ready (ana_ready),
        .ana_data  (ana_data)
    );

    // four entries of slack against out_ready
    result_fifo result_fifo_i (
        .clk       (clk),
        .reset     (reset),
        .ana_valid (ana_valid),
        .ana_ready (ana_ready),
        .ana_data  (ana_data),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_data  (buf_data)
    );

    // index encode, cost select, registered grant
    grant_encoder grant_encoder_i (
        .clk       (clk),
        .reset     (reset),
        .buf_valid (buf_valid),
        .buf_ready (buf_ready),
        .buf_data  (buf_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_grant (out_grant)
    );

endmodule

// File: src/min_finder.sv
`timescale 1ns/1ps

module min_finder import arb_pkg::*; (
    input  logic [NUM_LANES-1:0][EXT_COST_W-1:0] ext_costs,
    output logic [NUM_LANES-1:0]                 winner
);

    // full row of wins for lane i against every other lane
    logic [NUM_LANES-1:0] row [NUM_LANES];

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        for (genvar j = 0; j < NUM_LANES; j++) begin : g_pair
            if (j > i) begin : g_upper
                // lane i is no worse than later lane j
                assign row[i][j] = (ext_costs[i] <= ext_costs[j]);
            end else if (j < i) begin : g_lower
                // same pair comparison inverted, earlier lane keeps ties
                assign row[i][j] = ~(ext_costs[j] <= ext_costs[i]);
            end else begin : g_diag
                assign row[i][j] = 1'b1;
            end
        end
        // win only if no other lane beats this one
        assign winner[i] = &row[i];
    end

    // strict-before and non-strict-after must leave exactly one winner
    always_comb begin
        assert ($onehot(winner))
            else $error("min_finder: winner %b not one-hot", winner);
    end

endmodule

// File: src/ones_counter.sv
`timescale 1ns/1ps

module ones_counter import arb_pkg::*; (
    input  logic [NUM_LANES-1:0] mask,
    output logic [COUNT_W-1:0]   count
);

    // carry-sum group over 7 bits
    // result layout {a, b, c, s}: ones = s + 2 * (a + b + c)
    function automatic logic [3:0] cs_group(input logic [CS_GROUP_W-1:0] bits);
        logic [2:0] lo_ones;
        logic [1:0] hi_ones;
        logic       a;
        logic       b;
        logic       c;
        logic       s;
        // lower four bits, 0..4
        lo_ones = {2'b00, bits[0]} + {2'b00, bits[1]} + {2'b00, bits[2]} + {2'b00, bits[3]};
        // upper three bits, 0..3
        hi_ones = {1'b0, bits[4]} + {1'b0, bits[5]} + {1'b0, bits[6]};
        // odd total
        s = lo_ones[0] ^ hi_ones[0];
        // at least a pair in the lower half
        a = (lo_ones > 3'd1);
        // at least a pair in the upper half
        b = (hi_ones > 2'd1);
        // second pair of a full lower half, or the two odd ones together
        c = (lo_ones == 3'd4) | (lo_ones[0] & hi_ones[0]);
        return {a, b, c, s};
    endfunction

    // (7,3) counter, built from one more carry-sum group
    function automatic logic [2:0] pc_7_3(input logic [CS_GROUP_W-1:0] bits);
        logic [3:0] grp;
        logic [1:0] pairs;
        grp   = cs_group(bits);
        pairs = {1'b0, grp[3]} + {1'b0, grp[2]} + {1'b0, grp[1]};
        return {pairs, grp[0]};
    endfunction

    logic [PC_IN_W-1:0] pc_in;
    // carry-sum outputs of the two input groups
    logic [3:0]         grp0;
    logic [3:0]         grp1;
    // leftover bit plus the two sum bits
    logic [1:0]         tail_sum;
    // count of weight-two carries
    logic [2:0]         upper;

    // zero-pad the mask up to the 15-bit counter width
    assign pc_in = {{(PC_IN_W - NUM_LANES){1'b0}}, mask};

    assign grp0 = cs_group(pc_in[CS_GROUP_W-1:0]);
    assign grp1 = cs_group(pc_in[2*CS_GROUP_W-1:CS_GROUP_W]);

    // local adder, its carry joins the weight-two pool
    assign tail_sum = {1'b0, pc_in[PC_IN_W-1]} + {1'b0, grp0[0]} + {1'b0, grp1[0]};

    // six group carries and the tail carry, all weight two
    assign upper = pc_7_3({grp0[3:1], grp1[3:1], tail_sum[1]});

    assign count = {upper, tail_sum[0]};

    // more requests than lanes means the carry-sum tree is broken
    always_comb begin
        assert (count <= COUNT_W'(NUM_LANES))
            else $error("ones_counter: count %0d above lane total", count);
    end

endmodule

// File: src/req_analyzer.sv
`timescale 1ns/1ps

module req_analyzer import arb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  req_t      in_req,
    output logic      ana_valid,
    input  logic      ana_ready,
    output analysis_t ana_data
);

    // costs with the not-requesting flag on top
    logic [NUM_LANES-1:0][EXT_COST_W-1:0] ext_costs;
    logic [COUNT_W-1:0]                   req_count;
    logic [NUM_LANES-1:0]                 winner;
    // input handshake completes this cycle
    logic                                 take;

    // idle lanes get the top bit, so any requester beats them
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            ext_costs[i] = {~in_req.mask[i], in_req.costs[i]};
        end
    end

    ones_counter ones_counter_i (
        .mask  (in_req.mask),
        .count (req_count)
    );

    min_finder min_finder_i (
        .ext_costs (ext_costs),
        .winner    (winner)
    );

    // output register free when empty or draining this cycle
    assign in_ready = !ana_valid || ana_ready;
    assign take     = in_valid && in_ready;

    // valid follows the input only when the register can move
    always_ff @(posedge clk) begin
        if (reset) begin
            ana_valid <= 1'b0;
        end else if (in_ready) begin
            ana_valid <= in_valid;
        end
    end

    // payload, held under back-pressure
    always_ff @(posedge clk) begin
        if (take) begin
            ana_data.count  <= req_count;
            ana_data.winner <= winner;
            // raw costs, masking already done by the winner
            ana_data.costs  <= in_req.costs;
        end
    end

    // stalled result must not move until the buffer takes it
    assert property (@(posedge clk) disable iff (reset)
        ana_valid && !ana_ready |=> ana_valid && $stable(ana_data))
        else $error("req_analyzer: ana_data changed while stalled");

endmodule

// File: src/result_fifo.sv
`timescale 1ns/1ps

module result_fifo import arb_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      ana_valid,
    output logic      ana_ready,
    input  analysis_t ana_data,
    output logic      buf_valid,
    input  logic      buf_ready,
    output analysis_t buf_data
);

    // storage
    analysis_t             mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    // one extra bit to tell full from empty
    logic [FIFO_PTR_W:0]   occupancy;
    logic                  wr_en;
    logic                  rd_en;

    // full only blocks the producer, not the consumer's ready
    assign ana_ready = (occupancy != (FIFO_PTR_W + 1)'(FIFO_DEPTH));
    assign buf_valid = (occupancy != '0);
    // head entry, shows up the cycle after its write
    assign buf_data  = mem[rd_ptr];

    assign wr_en = ana_valid && ana_ready;
    assign rd_en = buf_valid && buf_ready;

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous read and write leaves the level alone
            case ({wr_en, rd_en})
                2'b10:   occupancy <= occupancy + 1'b1;
                2'b01:   occupancy <= occupancy - 1'b1;
                default: occupancy <= occupancy;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= ana_data;
        end
    end

    // level stays in range and agrees with the pointer distance
    assert property (@(posedge clk) disable iff (reset)
        occupancy <= (FIFO_PTR_W + 1)'(FIFO_DEPTH) &&
        occupancy[FIFO_PTR_W-1:0] == FIFO_PTR_W'(wr_ptr - rd_ptr))
        else $error("result_fifo: overflow or underflow, level %0d", occupancy);

endmodule

// File: verif/arb_tb.sv
`timescale 1ns/1ps

module arb_tb import arb_pkg::*; ();

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int SEED           = 68;
    localparam int NUM_TXN        = 400;
    localparam int BURST_LEN      = 16;
    // input transfer edge to output transfer edge, ready held high
    localparam int LATENCY        = 3;
    localparam int TIMEOUT_CYCLES = NUM_TXN * 12;
    localparam int DRAIN_LIMIT    = 64;

    logic   clk;
    logic   reset;
    logic   in_valid;
    logic   in_ready;
    req_t   in_req;
    logic   out_valid;
    logic   out_ready;
    grant_t out_grant;

    // model results in input order, with their input edge
    grant_t exp_q   [$];
    int     stamp_q [$];
    logic   timed_q [$];

    // latency checked only for requests sent in the burst
    logic   burst_mode;
    int     seq_errors;
    int     seq_checks;
    int     mon_errors;
    int     mon_checks;
    int     mon_grants;
    int     mon_empty;
    int     mon_full;
    int     mon_cycle;
    int     timeout_count;
    logic   stalled;
    grant_t held_grant;

    min_cost_arbiter min_cost_arbiter_i (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_grant (out_grant)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // lowest cost among requesters, first lane keeps a tie
    function automatic grant_t expected_grant(input req_t req);
        grant_t g;
        int     best;
        int     n;
        g    = '0;
        best = -1;
        n    = 0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (req.mask[i]) begin
                n++;
                if (best < 0 || req.costs[i] < req.costs[best]) begin
                    best = i;
                end
            end
        end
        g.count = COUNT_W'(n);
        if (best >= 0) begin
            g.index = LANE_W'(best);
            g.cost  = req.costs[best];
        end
        return g;
    endfunction

    // empty, single, full or random mask; small costs often, for ties
    function automatic req_t random_request();
        req_t r;
        int   kind;
        kind = int'($urandom_range(0, 7));
        case (kind)
            0:       r.mask = '0;
            1:       r.mask = NUM_LANES'(1) << $urandom_range(0, NUM_LANES - 1);
            2:       r.mask = '1;
            default: r.mask = NUM_LANES'($urandom_range(0, 255));
        endcase
        for (int i = 0; i < NUM_LANES; i++) begin
            if ($urandom_range(0, 2) == 0) begin
                r.costs[i] = COST_W'($urandom_range(0, 3));
            end else begin
                r.costs[i] = COST_W'($urandom_range(0, 31));
            end
        end
        return r;
    endfunction

    // valid held with its data until the DUT takes it
    task automatic drive_requests(input int n, input int valid_pct, input int ready_pct);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                sent++;
            end
            out_ready <= ($urandom_range(0, 99) < ready_pct);
            if (!in_valid || in_ready) begin
                if (sent < n && $urandom_range(0, 99) < valid_pct) begin
                    in_valid <= 1'b1;
                    in_req   <= random_request();
                end else begin
                    in_valid <= 1'b0;
                end
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        @(negedge clk);
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clk);
            n++;
        end
    endtask

    task automatic report_test(input string name, input string detail, input int err_before);
        int errs;
        errs = mon_errors + seq_errors - err_before;
        $display("test %s: %s, %0d errors%s", name, (errs == 0) ? "ok" : "FAILED", errs, detail);
    endtask

    // scoreboard, all values read before this edge's updates
    always @(posedge clk) begin : monitor
        grant_t exp_g;
        int     stamp;
        logic   timed;
        mon_cycle++;
        if (!reset) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_grant(in_req));
                stamp_q.push_back(mon_cycle);
                timed_q.push_back(burst_mode);
                if (in_req.mask == '0) begin
                    mon_empty++;
                end
                if (&in_req.mask) begin
                    mon_full++;
                end
            end
            // stalled grant must hold
            if (stalled) begin
                mon_checks++;
                if (out_valid !== 1'b1) begin
                    mon_errors++;
                    $display("ERR out_valid got %h exp 1 while stalled", out_valid);
                end else if (out_grant !== held_grant) begin
                    mon_errors++;
                    $display("ERR out_grant got %h exp %h while stalled", out_grant, held_grant);
                end
            end
            if (out_valid === 1'b1 && out_ready === 1'b1) begin
                mon_grants++;
                if (exp_q.size() == 0) begin
                    mon_errors++;
                    $display("grant %h came out with no request outstanding", out_grant);
                end else begin
                    exp_g = exp_q.pop_front();
                    stamp = stamp_q.pop_front();
                    timed = timed_q.pop_front();
                    mon_checks += 3;
                    if (out_grant.count !== exp_g.count) begin
                        mon_errors++;
                        $display("ERR out_grant.count got %h exp %h", out_grant.count, exp_g.count);
                    end
                    if (out_grant.index !== exp_g.index) begin
                        mon_errors++;
                        $display("ERR out_grant.index got %h exp %h", out_grant.index, exp_g.index);
                    end
                    if (out_grant.cost !== exp_g.cost) begin
                        mon_errors++;
                        $display("ERR out_grant.cost got %h exp %h", out_grant.cost, exp_g.cost);
                    end
                    if (timed) begin
                        mon_checks++;
                        if (mon_cycle - stamp != LATENCY) begin
                            mon_errors++;
                            $display("grant took %0d cycles, expected %0d", mon_cycle - stamp,
                                     LATENCY);
                        end
                    end
                end
            end
            stalled    = (out_valid === 1'b1) && (out_ready === 1'b0);
            held_grant = out_grant;
        end
    end

    // hang guard
    always @(posedge clk) begin
        timeout_count++;
        if (timeout_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d grants outstanding", timeout_count,
                     exp_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        int err_before;
        clk           = 1'b0;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_req        = '0;
        out_ready     = 1'b0;
        burst_mode    = 1'b0;
        seq_errors    = 0;
        seq_checks    = 0;
        mon_errors    = 0;
        mon_checks    = 0;
        mon_grants    = 0;
        mon_empty     = 0;
        mon_full      = 0;
        mon_cycle     = 0;
        timeout_count = 0;
        stalled       = 1'b0;
        held_grant    = '0;
        void'($urandom(SEED));

        // out_valid low through reset, in_ready high after it
        err_before = 0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin
                seq_checks++;
                if (out_valid !== 1'b0) begin
                    seq_errors++;
                    $display("ERR out_valid got %h exp 0 during reset", out_valid);
                end
            end
        end
        reset <= 1'b0;
        @(posedge clk);
        seq_checks += 2;
        if (out_valid !== 1'b0) begin
            seq_errors++;
            $display("ERR out_valid got %h exp 0 after reset", out_valid);
        end
        if (in_ready !== 1'b1) begin
            seq_errors++;
            $display("ERR in_ready got %h exp 1 after reset", in_ready);
        end
        report_test("reset_state", "", err_before);

        // count, winner, empty mask and ordering under random back-pressure
        err_before = mon_errors + seq_errors;
        drive_requests(NUM_TXN, 60, 70);
        out_ready <= 1'b1;
        wait_drain(DRAIN_LIMIT);
        report_test("random_traffic",
                    $sformatf(", %0d grants, %0d empty, %0d full masks",
                              mon_grants, mon_empty, mon_full),
                    err_before);

        // back to back requests, ready held high
        err_before = mon_errors + seq_errors;
        burst_mode = 1'b1;
        drive_requests(BURST_LEN, 100, 100);
        wait_drain(DRAIN_LIMIT);
        burst_mode = 1'b0;
        report_test("latency_burst", "", err_before);

        // idle cycles expose any late or duplicate grant
        err_before = mon_errors + seq_errors;
        repeat (8) @(negedge clk);
        seq_checks++;
        if (exp_q.size() != 0) begin
            seq_errors++;
            $display("%0d grants never came out", exp_q.size());
        end
        report_test("final_drain", "", err_before);

        $display("summary: %0d grants, %0d checks, %0d errors", mon_grants,
                 mon_checks + seq_checks, mon_errors + seq_errors);
        if (mon_errors + seq_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
